// ==== lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// register and memory bus widths
`define LSU_XLEN        32
`define LSU_BUS_W       64
`define LSU_BUS_BYTES   8

// transaction ids come from a free-running tick counter
`define LSU_ID_W        4
`define LSU_TICK_PERIOD 16

// response code field
`define LSU_RESP_W      2
`define LSU_RESP_FAULT  3

`endif

// ==== lsu_pkg.sv ====
`include "lsu_consts.svh"

package lsu_pkg;

	// memory operations handled by the unit
	typedef enum logic [3:0] {
		OP_LB  = 4'd0,
		OP_LBU = 4'd1,
		OP_LH  = 4'd2,
		OP_LHU = 4'd3,
		OP_LW  = 4'd4,
		OP_SB  = 4'd5,
		OP_SH  = 4'd6,
		OP_SW  = 4'd7
	} mem_op_t;

	// read or write address beat
	typedef struct packed {
		logic [`LSU_XLEN-1:0] addr;
		logic [`LSU_ID_W-1:0] id;
	} addr_beat_t;

	// write data beat, one strobe bit per byte lane
	typedef struct packed {
		logic [`LSU_BUS_W-1:0]     data;
		logic [`LSU_BUS_BYTES-1:0] strb;
	} wdata_beat_t;

endpackage

// ==== beat_sender.sv ====
`timescale 1ns/1ps

module beat_sender #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     send,
	input  payload_t payload,
	input  logic     ready,
	output logic     valid,
	output payload_t payload_out,
	output logic     accepted
);
	assign accepted = valid && ready;

	// valid stays up until the handshake
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (send) begin
			valid <= 1'b1;
		end else if (accepted) begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (send) begin
			payload_out <= payload;
		end
	end
endmodule

// ==== lsu_issue.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_issue (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 req_valid,
	input  lsu_pkg::mem_op_t     req_op,
	input  logic [`LSU_XLEN-1:0] req_addr,
	input  logic [`LSU_XLEN-1:0] req_wdata,
	input  logic                 done,
	output logic                 req_ready,
	output logic                 hold_valid,
	output lsu_pkg::mem_op_t     hold_op,
	output logic [`LSU_XLEN-1:0] hold_addr,
	output logic [`LSU_XLEN-1:0] hold_wdata
);
	// low through reset, high from the first cycle after it
	logic live;

	always_ff @(posedge clock) begin
		if (reset) begin
			live <= 1'b0;
		end else begin
			live <= 1'b1;
		end
	end

	// empty, or the current request finishes this cycle
	assign req_ready = live && (!hold_valid || done);

	always_ff @(posedge clock) begin
		if (reset) begin
			hold_valid <= 1'b0;
		end else if (req_ready) begin
			hold_valid <= req_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (req_valid && req_ready) begin
			hold_op    <= req_op;
			hold_addr  <= req_addr;
			hold_wdata <= req_wdata;
		end
	end
endmodule

// ==== access_split.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module access_split (
	input  lsu_pkg::mem_op_t     hold_op,
	input  logic [`LSU_XLEN-1:0] hold_addr,
	input  logic [`LSU_XLEN-1:0] hold_wdata,
	input  logic                 second_beat,
	output logic                 is_store,
	output logic                 two_beats,
	output logic [`LSU_XLEN-1:0] beat_addr,
	output lsu_pkg::wdata_beat_t beat_wdata
);
	logic [3:0]                  size_bytes;
	logic [3:0]                  size_mask;
	logic [2:0]                  offset;
	logic [`LSU_XLEN-1:0]        aligned_addr;
	logic [2*`LSU_BUS_W-1:0]     data_window;
	logic [2*`LSU_BUS_BYTES-1:0] strb_window;

	always_comb begin
		case (hold_op)
			lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: begin
				size_bytes = 4'd2;
				size_mask  = 4'b0011;
			end
			lsu_pkg::OP_LW, lsu_pkg::OP_SW: begin
				size_bytes = 4'd4;
				size_mask  = 4'b1111;
			end
			default: begin
				size_bytes = 4'd1;
				size_mask  = 4'b0001;
			end
		endcase
	end

	assign is_store = (hold_op == lsu_pkg::OP_SB) || (hold_op == lsu_pkg::OP_SH)
		|| (hold_op == lsu_pkg::OP_SW);

	assign offset       = hold_addr[2:0];
	assign aligned_addr = {hold_addr[`LSU_XLEN-1:3], 3'b000};

	// the access runs past lane 7 of the first doubleword
	assign two_beats = ({1'b0, offset} + size_bytes) > 4'(`LSU_BUS_BYTES);

	assign beat_addr = second_beat ? aligned_addr + `LSU_XLEN'(`LSU_BUS_BYTES) : aligned_addr;

	// place data and strobes across two doublewords, low half is the first beat
	assign data_window = {{(2*`LSU_BUS_W-`LSU_XLEN){1'b0}}, hold_wdata} << {offset, 3'b000};
	assign strb_window = {{(2*`LSU_BUS_BYTES-4){1'b0}}, size_mask} << offset;

	always_comb begin
		if (second_beat) begin
			beat_wdata.data = data_window[2*`LSU_BUS_W-1:`LSU_BUS_W];
			beat_wdata.strb = strb_window[2*`LSU_BUS_BYTES-1:`LSU_BUS_BYTES];
		end else begin
			beat_wdata.data = data_window[`LSU_BUS_W-1:0];
			beat_wdata.strb = strb_window[`LSU_BUS_BYTES-1:0];
		end
	end
endmodule

// ==== lsu_ctrl.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_ctrl (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   hold_valid,
	input  logic                   is_store,
	input  logic                   two_beats,
	input  logic [`LSU_XLEN-1:0]   beat_addr,
	input  lsu_pkg::wdata_beat_t   beat_wdata,
	input  logic                   ar_accepted,
	input  logic                   aw_accepted,
	input  logic                   w_accepted,
	input  logic                   bvalid,
	input  logic [`LSU_ID_W-1:0]   bid,
	input  logic [`LSU_RESP_W-1:0] bresp,
	input  logic                   rvalid,
	input  logic [`LSU_ID_W-1:0]   rid,
	input  logic [`LSU_RESP_W-1:0] rresp,
	output logic                   ar_send,
	output logic                   aw_send,
	output logic                   w_send,
	output lsu_pkg::addr_beat_t    ar_payload,
	output lsu_pkg::addr_beat_t    aw_payload,
	output lsu_pkg::wdata_beat_t   w_payload,
	output logic                   bready,
	output logic                   rready,
	output logic                   second_beat,
	output logic                   capture_first,
	output logic                   done,
	output logic                   resp_err
);
	typedef enum logic [1:0] {
		R_IDLE,
		R_ADDR,
		R_DATA
	} rd_state_t;

	typedef enum logic [1:0] {
		W_IDLE,
		W_ADDR,
		W_RESP
	} wr_state_t;

	rd_state_t            rd_state;
	wr_state_t            wr_state;
	logic [`LSU_ID_W-1:0] tick;
	logic [`LSU_ID_W-1:0] cur_id;
	logic                 aw_got;
	logic                 w_got;
	logic                 err_seen;
	logic                 both_idle;
	logic                 r_hit;
	logic                 b_hit;
	logic                 r_more;
	logic                 b_more;
	logic                 rd_launch;
	logic                 wr_launch;

	always_ff @(posedge clock) begin
		if (reset) begin
			tick <= '0;
		end else begin
			tick <= (tick == `LSU_ID_W'(`LSU_TICK_PERIOD - 1)) ? '0 : tick + 1'b1;
		end
	end

	assign both_idle = (rd_state == R_IDLE) && (wr_state == W_IDLE);
	assign rready    = (rd_state == R_DATA);
	assign bready    = (wr_state == W_RESP);

	// responses with another id are stale and get dropped
	assign r_hit  = rvalid && rready && (rid == cur_id);
	assign b_hit  = bvalid && bready && (bid == cur_id);
	assign r_more = r_hit && two_beats && !second_beat;
	assign b_more = b_hit && two_beats && !second_beat;

	assign rd_launch = (both_idle && hold_valid && !is_store) || r_more;
	assign wr_launch = (both_idle && hold_valid && is_store) || b_more;

	assign done          = (r_hit && !r_more) || (b_hit && !b_more);
	assign capture_first = r_more;
	assign resp_err      = done && (err_seen
		|| (r_hit && rresp == `LSU_RESP_W'(`LSU_RESP_FAULT))
		|| (b_hit && bresp == `LSU_RESP_W'(`LSU_RESP_FAULT)));

	assign ar_payload = '{addr: beat_addr, id: cur_id};
	assign aw_payload = '{addr: beat_addr, id: cur_id};
	assign w_payload  = beat_wdata;

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_state <= R_IDLE;
			ar_send  <= 1'b0;
		end else begin
			ar_send <= rd_launch;
			case (rd_state)
				R_IDLE: if (rd_launch) rd_state <= R_ADDR;
				R_ADDR: if (ar_accepted) rd_state <= R_DATA;
				R_DATA: if (r_hit) rd_state <= r_more ? R_ADDR : R_IDLE;
				default: rd_state <= R_IDLE;
			endcase
		end
	end

	// aw and w may be accepted in either order
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_state <= W_IDLE;
			aw_send  <= 1'b0;
			w_send   <= 1'b0;
			aw_got   <= 1'b0;
			w_got    <= 1'b0;
		end else begin
			aw_send <= wr_launch;
			w_send  <= wr_launch;
			aw_got  <= !wr_launch && (aw_got || aw_accepted);
			w_got   <= !wr_launch && (w_got || w_accepted);
			case (wr_state)
				W_IDLE: if (wr_launch) wr_state <= W_ADDR;
				W_ADDR: if ((aw_got || aw_accepted) && (w_got || w_accepted)) wr_state <= W_RESP;
				W_RESP: if (b_hit) wr_state <= b_more ? W_ADDR : W_IDLE;
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	// beat id, second-beat flag and sticky fault for the request in flight
	always_ff @(posedge clock) begin
		if (reset) begin
			cur_id      <= '0;
			second_beat <= 1'b0;
			err_seen    <= 1'b0;
		end else begin
			if (rd_launch || wr_launch) begin
				cur_id <= tick;
			end
			if (done) begin
				second_beat <= 1'b0;
				err_seen    <= 1'b0;
			end else if (r_more || b_more) begin
				second_beat <= 1'b1;
				err_seen    <= (r_more && rresp == `LSU_RESP_W'(`LSU_RESP_FAULT))
					|| (b_more && bresp == `LSU_RESP_W'(`LSU_RESP_FAULT));
			end
		end
	end
endmodule

// ==== load_align.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module load_align (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  capture_first,
	input  logic [`LSU_BUS_W-1:0] rdata,
	input  lsu_pkg::mem_op_t      hold_op,
	input  logic [`LSU_XLEN-1:0]  hold_addr,
	input  logic                  two_beats,
	output logic [`LSU_XLEN-1:0]  resp_data
);
	logic [`LSU_BUS_W-1:0]   first_beat;
	logic [2*`LSU_BUS_W-1:0] window;
	logic [`LSU_XLEN-1:0]    picked;

	always_ff @(posedge clock) begin
		if (reset) begin
			first_beat <= '0;
		end else if (capture_first) begin
			first_beat <= rdata;
		end
	end

	// on a crossing the second beat supplies the upper bytes
	assign window = two_beats ? {rdata, first_beat} : {{`LSU_BUS_W{1'b0}}, rdata};
	assign picked = `LSU_XLEN'(window >> {hold_addr[2:0], 3'b000});

	always_comb begin
		case (hold_op)
			lsu_pkg::OP_LB: begin
				resp_data = {{(`LSU_XLEN-8){picked[7]}}, picked[7:0]};
			end
			lsu_pkg::OP_LBU: begin
				resp_data = {{(`LSU_XLEN-8){1'b0}}, picked[7:0]};
			end
			lsu_pkg::OP_LH: begin
				resp_data = {{(`LSU_XLEN-16){picked[15]}}, picked[15:0]};
			end
			lsu_pkg::OP_LHU: begin
				resp_data = {{(`LSU_XLEN-16){1'b0}}, picked[15:0]};
			end
			// lw, and stores where the value is not used
			default: begin
				resp_data = picked;
			end
		endcase
	end
endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_top (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      req_valid,
	input  lsu_pkg::mem_op_t          req_op,
	input  logic [`LSU_XLEN-1:0]      req_addr,
	input  logic [`LSU_XLEN-1:0]      req_wdata,
	output logic                      req_ready,
	output logic                      resp_valid,
	output logic [`LSU_XLEN-1:0]      resp_data,
	output logic                      resp_err,
	output logic                      awvalid,
	input  logic                      awready,
	output logic [`LSU_XLEN-1:0]      awaddr,
	output logic [`LSU_ID_W-1:0]      awid,
	output logic                      wvalid,
	input  logic                      wready,
	output logic [`LSU_BUS_W-1:0]     wdata,
	output logic [`LSU_BUS_BYTES-1:0] wstrb,
	input  logic                      bvalid,
	output logic                      bready,
	input  logic [`LSU_ID_W-1:0]      bid,
	input  logic [`LSU_RESP_W-1:0]    bresp,
	output logic                      arvalid,
	input  logic                      arready,
	output logic [`LSU_XLEN-1:0]      araddr,
	output logic [`LSU_ID_W-1:0]      arid,
	input  logic                      rvalid,
	output logic                      rready,
	input  logic [`LSU_BUS_W-1:0]     rdata,
	input  logic [`LSU_ID_W-1:0]      rid,
	input  logic [`LSU_RESP_W-1:0]    rresp
);
	logic                 hold_valid;
	lsu_pkg::mem_op_t     hold_op;
	logic [`LSU_XLEN-1:0] hold_addr;
	logic [`LSU_XLEN-1:0] hold_wdata;
	logic                 is_store;
	logic                 two_beats;
	logic                 second_beat;
	logic [`LSU_XLEN-1:0] beat_addr;
	lsu_pkg::wdata_beat_t beat_wdata;
	logic                 capture_first;
	logic                 ar_send;
	logic                 aw_send;
	logic                 w_send;
	lsu_pkg::addr_beat_t  ar_payload;
	lsu_pkg::addr_beat_t  aw_payload;
	lsu_pkg::wdata_beat_t w_payload;
	logic                 ar_accepted;
	logic                 aw_accepted;
	logic                 w_accepted;

	// resp_valid doubles as the done pulse that frees the holding register
	lsu_issue u_issue (
		.clock(clock), .reset(reset),
		.req_valid(req_valid), .req_op(req_op), .req_addr(req_addr), .req_wdata(req_wdata),
		.done(resp_valid), .req_ready(req_ready),
		.hold_valid(hold_valid), .hold_op(hold_op), .hold_addr(hold_addr),
		.hold_wdata(hold_wdata)
	);

	access_split u_split (
		.hold_op(hold_op), .hold_addr(hold_addr), .hold_wdata(hold_wdata),
		.second_beat(second_beat), .is_store(is_store), .two_beats(two_beats),
		.beat_addr(beat_addr), .beat_wdata(beat_wdata)
	);

	lsu_ctrl u_ctrl (
		.clock(clock), .reset(reset),
		.hold_valid(hold_valid), .is_store(is_store), .two_beats(two_beats),
		.beat_addr(beat_addr), .beat_wdata(beat_wdata),
		.ar_accepted(ar_accepted), .aw_accepted(aw_accepted), .w_accepted(w_accepted),
		.bvalid(bvalid), .bid(bid), .bresp(bresp),
		.rvalid(rvalid), .rid(rid), .rresp(rresp),
		.ar_send(ar_send), .aw_send(aw_send), .w_send(w_send),
		.ar_payload(ar_payload), .aw_payload(aw_payload), .w_payload(w_payload),
		.bready(bready), .rready(rready), .second_beat(second_beat),
		.capture_first(capture_first), .done(resp_valid), .resp_err(resp_err)
	);

	load_align u_align (
		.clock(clock), .reset(reset), .capture_first(capture_first), .rdata(rdata),
		.hold_op(hold_op), .hold_addr(hold_addr), .two_beats(two_beats),
		.resp_data(resp_data)
	);

	beat_sender #(.payload_t(lsu_pkg::addr_beat_t)) ar_sender (
		.clock(clock), .reset(reset), .send(ar_send), .payload(ar_payload),
		.ready(arready), .valid(arvalid), .payload_out({araddr, arid}),
		.accepted(ar_accepted)
	);

	beat_sender #(.payload_t(lsu_pkg::addr_beat_t)) aw_sender (
		.clock(clock), .reset(reset), .send(aw_send), .payload(aw_payload),
		.ready(awready), .valid(awvalid), .payload_out({awaddr, awid}),
		.accepted(aw_accepted)
	);

	beat_sender #(.payload_t(lsu_pkg::wdata_beat_t)) w_sender (
		.clock(clock), .reset(reset), .send(w_send), .payload(w_payload),
		.ready(wready), .valid(wvalid), .payload_out({wdata, wstrb}),
		.accepted(w_accepted)
	);
endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_mem_model (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      stress,
	input  logic                      fault_on,
	input  logic                      awvalid,
	output logic                      awready,
	input  logic [`LSU_XLEN-1:0]      awaddr,
	input  logic [`LSU_ID_W-1:0]      awid,
	input  logic                      wvalid,
	output logic                      wready,
	input  logic [`LSU_BUS_W-1:0]     wdata,
	input  logic [`LSU_BUS_BYTES-1:0] wstrb,
	output logic                      bvalid,
	input  logic                      bready,
	output logic [`LSU_ID_W-1:0]      bid,
	output logic [`LSU_RESP_W-1:0]    bresp,
	input  logic                      arvalid,
	output logic                      arready,
	input  logic [`LSU_XLEN-1:0]      araddr,
	input  logic [`LSU_ID_W-1:0]      arid,
	output logic                      rvalid,
	input  logic                      rready,
	output logic [`LSU_BUS_W-1:0]     rdata,
	output logic [`LSU_ID_W-1:0]      rid,
	output logic [`LSU_RESP_W-1:0]    rresp
);
	logic [7:0] mem [logic [31:0]];

	// unwritten bytes read back a pattern of their whole address
	function automatic logic [7:0] mem_byte(logic [31:0] a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
	endfunction

	task automatic pause();
		if (stress) begin
			repeat ($urandom_range(0, 4)) @(posedge clock);
		end
	endtask

	task automatic serve_read();
		logic [31:0] a;
		logic [3:0]  id;
		logic [63:0] d;
		a  = araddr;
		id = arid;
		pause();
		arready <= 1'b1;
		@(posedge clock);
		arready <= 1'b0;
		for (int i = 0; i < 8; i++) begin
			d[8*i +: 8] = mem_byte(a + 32'(i));
		end
		pause();
		// stale beat with a wrong id and a fault code, must be dropped
		if (stress && $urandom_range(0, 1) == 1) begin
			rvalid <= 1'b1;
			rid    <= id ^ 4'h8;
			rdata  <= ~d;
			rresp  <= 2'd3;
			do @(posedge clock); while (!rready);
		end
		rvalid <= 1'b1;
		rid    <= id;
		rdata  <= d;
		// faults hit only doublewords with address bit 3 clear
		rresp  <= (fault_on && !a[3]) ? 2'd3 : 2'd0;
		do @(posedge clock); while (!rready);
		rvalid <= 1'b0;
	endtask

	task automatic serve_write();
		logic [31:0] a;
		logic [3:0]  id;
		logic [63:0] d;
		logic [7:0]  s;
		a  = awaddr;
		id = awid;
		pause();
		awready <= 1'b1;
		@(posedge clock);
		awready <= 1'b0;
		pause();
		wready <= 1'b1;
		@(posedge clock);
		wready <= 1'b0;
		d = wdata;
		s = wstrb;
		for (int i = 0; i < 8; i++) begin
			if (s[i]) begin
				mem[a + 32'(i)] = d[8*i +: 8];
			end
		end
		pause();
		if (stress && $urandom_range(0, 1) == 1) begin
			bvalid <= 1'b1;
			bid    <= id ^ 4'h8;
			bresp  <= 2'd3;
			do @(posedge clock); while (!bready);
		end
		bvalid <= 1'b1;
		bid    <= id;
		bresp  <= (fault_on && !a[3]) ? 2'd3 : 2'd0;
		do @(posedge clock); while (!bready);
		bvalid <= 1'b0;
	endtask

	initial begin
		awready = 1'b0;
		wready  = 1'b0;
		bvalid  = 1'b0;
		bid     = '0;
		bresp   = '0;
		arready = 1'b0;
		rvalid  = 1'b0;
		rdata   = '0;
		rid     = '0;
		rresp   = '0;
		forever begin
			@(posedge clock);
			if (!reset && arvalid) begin
				serve_read();
			end else if (!reset && (awvalid || wvalid)) begin
				serve_write();
			end
		end
	end
endmodule

// ==== lsu_properties.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_properties (
	input logic                      clock,
	input logic                      reset,
	input logic                      arvalid,
	input logic                      arready,
	input logic [`LSU_XLEN-1:0]      araddr,
	input logic [`LSU_ID_W-1:0]      arid,
	input logic                      awvalid,
	input logic                      awready,
	input logic [`LSU_XLEN-1:0]      awaddr,
	input logic [`LSU_ID_W-1:0]      awid,
	input logic                      wvalid,
	input logic                      wready,
	input logic [`LSU_BUS_W-1:0]     wdata,
	input logic [`LSU_BUS_BYTES-1:0] wstrb,
	input logic                      resp_valid,
	input logic                      req_valid,
	input logic                      req_ready
);
	logic in_flight;

	// outstanding from acceptance until its resp_valid
	always_ff @(posedge clock) begin
		if (reset) begin
			in_flight <= 1'b0;
		end else if (req_valid && req_ready) begin
			in_flight <= 1'b1;
		end else if (resp_valid) begin
			in_flight <= 1'b0;
		end
	end

	// a beat waiting for ready keeps its payload
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable({araddr, arid}))
		else $error("arvalid dropped or payload changed before arready");

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable({awaddr, awid}))
		else $error("awvalid dropped or payload changed before awready");

	w_hold: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable({wdata, wstrb}))
		else $error("wvalid dropped or payload changed before wready");

	resp_pulse: assert property (@(posedge clock) disable iff (reset)
		resp_valid |=> !resp_valid)
		else $error("resp_valid longer than one cycle");

	busy_stall: assert property (@(posedge clock) disable iff (reset)
		in_flight && !resp_valid |-> !req_ready)
		else $error("req_ready high while a request is in flight");
endmodule

bind lsu_top lsu_properties u_props (
	.clock(clock), .reset(reset),
	.arvalid(arvalid), .arready(arready), .araddr(araddr), .arid(arid),
	.awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awid(awid),
	.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
	.resp_valid(resp_valid), .req_valid(req_valid), .req_ready(req_ready)
);

// ==== tb_lsu.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsu;
	localparam int ALIGNED_ITERS = 8;
	localparam int CROSS_ITERS   = 10;
	localparam int STRESS_REQS   = 40;
	localparam int FAULT_REQS    = 6;
	localparam int REQ_TOTAL     = ALIGNED_ITERS * 9 + CROSS_ITERS * 5 + STRESS_REQS + FAULT_REQS;
	localparam int CYCLE_LIMIT   = 200 * REQ_TOTAL;

	logic clock, reset, stress, fault_on;
	logic req_valid, req_ready, resp_valid, resp_err;
	lsu_pkg::mem_op_t req_op;
	logic [`LSU_XLEN-1:0] req_addr, req_wdata, resp_data, awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready, rvalid, rready;
	logic [`LSU_ID_W-1:0] awid, bid, arid, rid;
	logic [`LSU_RESP_W-1:0] bresp, rresp;
	logic [`LSU_BUS_W-1:0] wdata, rdata;
	logic [`LSU_BUS_BYTES-1:0] wstrb;

	logic [7:0]  shadow [logic [31:0]];
	logic [31:0] exp_data_q [$];
	logic        exp_load_q [$];
	logic        exp_err_q [$];
	int errors, checks, issued, resp_count, cycles, ar_beats, aw_beats, w_beats;

	lsu_top DUT (.*);

	tb_mem_model u_mem (.*);

	always #2 clock = ~clock;

	function automatic logic [7:0] byte_at(logic [31:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
	endfunction

	function automatic int size_of(lsu_pkg::mem_op_t op);
		case (op)
			lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: return 2;
			lsu_pkg::OP_LW, lsu_pkg::OP_SW: return 4;
			default: return 1;
		endcase
	endfunction

	// little-endian gather from the shadow, then extend per op
	function automatic logic [31:0] expected_load(lsu_pkg::mem_op_t op, logic [31:0] addr);
		logic [31:0] w;
		w = {byte_at(addr + 32'd3), byte_at(addr + 32'd2), byte_at(addr + 32'd1), byte_at(addr)};
		case (op)
			lsu_pkg::OP_LB:  return {{24{w[7]}}, w[7:0]};
			lsu_pkg::OP_LBU: return {24'h0, w[7:0]};
			lsu_pkg::OP_LH:  return {{16{w[15]}}, w[15:0]};
			lsu_pkg::OP_LHU: return {16'h0, w[15:0]};
			default:         return w;
		endcase
	endfunction

	task automatic check_beats(string name, int got, int want);
		if (got != want) begin
			$display("ERR t=%0t %s beats expected %0d got %0d", $time, name, want, got);
			errors++;
		end
	endtask

	task automatic do_request(lsu_pkg::mem_op_t op, logic [31:0] addr, logic [31:0] data);
		logic store;
		int   ar0, aw0, w0, want;
		store = (op == lsu_pkg::OP_SB) || (op == lsu_pkg::OP_SH) || (op == lsu_pkg::OP_SW);
		want  = (int'(addr[2:0]) + size_of(op) > 8) ? 2 : 1;
		if (store) begin
			for (int i = 0; i < size_of(op); i++) begin
				shadow[addr + 32'(i)] = data[8*i +: 8];
			end
		end
		exp_data_q.push_back(store ? 32'h0 : expected_load(op, addr));
		exp_load_q.push_back(!store);
		// the memory faults only doublewords with address bit 3 clear
		// a crossing always touches one of them
		exp_err_q.push_back(fault_on && (want == 2 || !addr[3]));
		ar0 = ar_beats;
		aw0 = aw_beats;
		w0  = w_beats;
		req_valid <= 1'b1;
		req_op    <= op;
		req_addr  <= addr;
		req_wdata <= data;
		do @(posedge clock); while (!req_ready);
		req_valid <= 1'b0;
		issued++;
		while (resp_count < issued) @(posedge clock);
		if (store) begin
			check_beats("awvalid", aw_beats - aw0, want);
			check_beats("wvalid", w_beats - w0, want);
		end else begin
			check_beats("arvalid", ar_beats - ar0, want);
		end
	endtask

	task automatic report_test(string name, int err_before);
		$display("test %s: %s", name, (errors == err_before) ? "ok" : "FAILED");
	endtask

	always @(posedge clock) begin
		if (arvalid && arready) ar_beats <= ar_beats + 1;
		if (awvalid && awready) aw_beats <= aw_beats + 1;
		if (wvalid && wready) w_beats <= w_beats + 1;
	end

	// compare each result against the queued expectation
	always @(posedge clock) begin
		logic [31:0] exp_data;
		logic        exp_load;
		logic        exp_err;
		if (!reset && resp_valid) begin
			resp_count <= resp_count + 1;
			if (exp_data_q.size() == 0) begin
				$display("resp_valid at t=%0t with no request outstanding", $time);
				errors++;
			end else begin
				exp_data = exp_data_q.pop_front();
				exp_load = exp_load_q.pop_front();
				exp_err  = exp_err_q.pop_front();
				checks++;
				if (exp_load && resp_data !== exp_data) begin
					$display("ERR t=%0t resp_data expected %h got %h", $time, exp_data, resp_data);
					errors++;
				end
				if (resp_err !== exp_err) begin
					$display("ERR t=%0t resp_err expected %b got %b", $time, exp_err, resp_err);
					errors++;
				end
			end
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run timed out waiting for a response after %0d cycles", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		int          e0;
		logic [31:0] a;
		clock = 1'b0;
		reset = 1'b1;
		stress = 1'b0;
		fault_on = 1'b0;
		req_valid = 1'b0;
		req_op = lsu_pkg::OP_LB;
		req_addr = '0;
		req_wdata = '0;
		{errors, checks, issued, resp_count, cycles, ar_beats, aw_beats, w_beats} = '0;
		void'($urandom(35));

		// outputs stay quiet through reset and the release edge
		e0 = errors;
		@(posedge clock);
		for (int c = 0; c < 5; c++) begin
			@(posedge clock);
			if (c == 3) reset <= 1'b0;
			if (arvalid || awvalid || wvalid || rready || bready || resp_valid || req_ready) begin
				$display("valid or ready output high at t=%0t during reset", $time);
				errors++;
			end
		end
		report_test("reset", e0);

		e0 = errors;
		for (int i = 0; i < ALIGNED_ITERS; i++) begin
			a = 32'h1000 + 32'(4 * $urandom_range(0, 31));
			do_request(lsu_pkg::OP_SW, a, $urandom());
			do_request(lsu_pkg::OP_LW, a, 32'h0);
			do_request(lsu_pkg::OP_SB, a + 32'($urandom_range(0, 3)), $urandom());
			do_request(lsu_pkg::OP_SH, a + 32'(2 * $urandom_range(0, 1)), $urandom());
			do_request(lsu_pkg::OP_LB, a + 32'($urandom_range(0, 3)), 32'h0);
			do_request(lsu_pkg::OP_LBU, a + 32'($urandom_range(0, 3)), 32'h0);
			do_request(lsu_pkg::OP_LH, a + 32'(2 * $urandom_range(0, 1)), 32'h0);
			do_request(lsu_pkg::OP_LHU, a + 32'(2 * $urandom_range(0, 1)), 32'h0);
			do_request(lsu_pkg::OP_LW, a, 32'h0);
		end
		report_test("aligned", e0);

		e0 = errors;
		for (int i = 0; i < CROSS_ITERS; i++) begin
			a = 32'h1000 + 32'(8 * $urandom_range(0, 15));
			do_request(lsu_pkg::OP_SW, a + 32'($urandom_range(5, 7)), $urandom());
			do_request(lsu_pkg::OP_SH, a + 32'd7, $urandom());
			do_request(lsu_pkg::OP_LW, a + 32'($urandom_range(5, 7)), 32'h0);
			do_request(lsu_pkg::OP_LH, a + 32'd7, 32'h0);
			do_request(lsu_pkg::OP_LHU, a + 32'd7, 32'h0);
		end
		report_test("crossing", e0);

		// random delays and stale ids on every channel from here on
		e0 = errors;
		stress = 1'b1;
		for (int i = 0; i < STRESS_REQS; i++) begin
			do_request(lsu_pkg::mem_op_t'($urandom_range(0, 7)),
				32'h1000 + 32'($urandom_range(0, 63)), $urandom());
		end
		report_test("stress", e0);

		// first beat only, second beat only, then single beats
		e0 = errors;
		fault_on = 1'b1;
		do_request(lsu_pkg::OP_LW, 32'h1006, 32'h0);
		do_request(lsu_pkg::OP_SW, 32'h100d, $urandom());
		do_request(lsu_pkg::OP_LB, 32'h1011, 32'h0);
		do_request(lsu_pkg::OP_SB, 32'h1012, $urandom());
		fault_on = 1'b0;
		do_request(lsu_pkg::OP_LW, 32'h100d, 32'h0);
		do_request(lsu_pkg::OP_SW, 32'h1015, $urandom());
		report_test("fault", e0);

		$display("requests %0d checks %0d errors %0d", issued, checks, errors);
		if (errors == 0 && checks == REQ_TOTAL) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end
endmodule

// ==== sim.f ====
+incdir+.
lsu_pkg.sv
beat_sender.sv
lsu_issue.sv
access_split.sv
lsu_ctrl.sv
load_align.sv
lsu_top.sv
tb_mem_model.sv
lsu_properties.sv
tb_lsu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Regression passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
